/* design/axil_bram.sv */
`timescale 1ns/1ps
`default_nettype none

`include "soc_defines.svh"

module axil_bram
    import soc_bus_pkg::*;
(
    input  logic      i_clk,
    input  logic      i_rst_n,
    input  axil_req_t i_axil,
    output axil_rsp_t o_axil
);

    localparam int IDX_W = $clog2(`SOC_MEM_WORDS);

    data_t mem [`SOC_MEM_WORDS];

    logic  arready_q;
    logic  wr_ready_q;
    logic  rvalid_q;
    logic  bvalid_q;
    data_t rdata_q;

    logic             w_ar_fire;
    logic             w_wr_fire;
    logic [IDX_W-1:0] w_rd_idx;
    logic [IDX_W-1:0] w_wr_idx;

    assign w_ar_fire = i_axil.arvalid && arready_q;
    assign w_wr_fire = i_axil.awvalid && i_axil.wvalid && wr_ready_q;
    // Word index, upper address bits wrap around the array
    assign w_rd_idx  = i_axil.araddr[IDX_W+1:2];
    assign w_wr_idx  = i_axil.awaddr[IDX_W+1:2];

    // ----------------------------------------
    // Handshake control
    // ----------------------------------------
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            arready_q  <= 1'b0;
            wr_ready_q <= 1'b0;
            rvalid_q   <= 1'b0;
            bvalid_q   <= 1'b0;
        end else begin
            if (w_ar_fire) begin
                arready_q <= 1'b0;
                rvalid_q  <= 1'b1;
            end else if (i_axil.arvalid && !arready_q && !rvalid_q) begin
                arready_q <= 1'b1;
            end
            if (rvalid_q && i_axil.rready) begin
                rvalid_q <= 1'b0;
            end

            // AW and W are taken together
            if (w_wr_fire) begin
                wr_ready_q <= 1'b0;
                bvalid_q   <= 1'b1;
            end else if (i_axil.awvalid && i_axil.wvalid && !wr_ready_q && !bvalid_q) begin
                wr_ready_q <= 1'b1;
            end
            if (bvalid_q && i_axil.bready) begin
                bvalid_q <= 1'b0;
            end
        end
    end

    // Storage with byte strobes
    always_ff @(posedge i_clk) begin
        if (w_ar_fire) begin
            rdata_q <= mem[w_rd_idx];
        end
        if (w_wr_fire) begin
            for (int b = 0; b < `SOC_STRB_W; b++) begin
                if (i_axil.wstrb[b]) begin
                    mem[w_wr_idx][8*b +: 8] <= i_axil.wdata[8*b +: 8];
                end
            end
        end
    end

    always_comb begin
        o_axil.awready = wr_ready_q;
        o_axil.wready  = wr_ready_q;
        o_axil.bresp   = OKAY;
        o_axil.bvalid  = bvalid_q;
        o_axil.arready = arready_q;
        o_axil.rdata   = rdata_q;
        o_axil.rresp   = OKAY;
        o_axil.rvalid  = rvalid_q;
    end

endmodule : axil_bram

`default_nettype wire

/* design/axil_xbar.sv */
`timescale 1ns/1ps
`default_nettype none

`include "soc_defines.svh"

module axil_xbar
    import soc_bus_pkg::*;
(
    input  logic            i_clk,
    input  logic            i_rst_n,
    input  axil_req_t [1:0] i_mgr,
    output axil_rsp_t [1:0] o_mgr,
    output axil_req_t [1:0] o_sub,
    input  axil_rsp_t [1:0] i_sub
);

    xbar_state_t state_q;
    logic        sel_q;
    logic        tgt_q;
    logic        miss_q;
    logic        rd_q;

    logic      w_m0_valid;
    logic      w_m1_valid;
    logic      w_win;
    logic      w_rd;
    addr_t     w_addr;
    logic      w_hit_mem;
    logic      w_hit_peri;
    axil_req_t w_req;
    axil_rsp_t w_rsp;
    logic      w_done;

    // ----------------------------------------
    // Arbitration and decode
    // ----------------------------------------
    // ibus (master 0) always wins a tie
    assign w_m0_valid = i_mgr[0].arvalid || i_mgr[0].awvalid;
    assign w_m1_valid = i_mgr[1].arvalid || i_mgr[1].awvalid;
    assign w_win      = !w_m0_valid;
    // Read goes first if both AR and AW are up
    assign w_rd       = i_mgr[w_win].arvalid;
    assign w_addr     = w_rd ? i_mgr[w_win].araddr : i_mgr[w_win].awaddr;
    assign w_hit_mem  = (w_addr & `SOC_MEM_MASK) == `SOC_MEM_BASE;
    assign w_hit_peri = (w_addr & `SOC_PERI_MASK) == `SOC_PERI_BASE;

    assign w_req = i_mgr[sel_q];
    assign w_rsp = i_sub[tgt_q];

    // End of the current phase
    always_comb begin
        case (state_q)
            XB_ROUTE: begin
                if (miss_q) begin
                    w_done = rd_q ? w_req.arvalid : (w_req.awvalid && w_req.wvalid);
                end else begin
                    w_done = rd_q ? (w_rsp.rvalid && w_req.rready)
                                  : (w_rsp.bvalid && w_req.bready);
                end
            end
            XB_DONE: w_done = rd_q ? w_req.rready : w_req.bready;
            default: w_done = 1'b0;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q <= XB_IDLE;
            sel_q   <= 1'b0;
            tgt_q   <= 1'b0;
            miss_q  <= 1'b0;
            rd_q    <= 1'b0;
        end else begin
            case (state_q)
                XB_IDLE: begin
                    if (w_m0_valid || w_m1_valid) begin
                        state_q <= XB_ROUTE;
                        sel_q   <= w_win;
                        rd_q    <= w_rd;
                        tgt_q   <= !w_hit_mem;
                        miss_q  <= !(w_hit_mem || w_hit_peri);
                    end
                end
                XB_ROUTE: begin
                    if (w_done) begin
                        state_q <= miss_q ? XB_DONE : XB_IDLE;
                    end
                end
                XB_DONE: begin
                    if (w_done) begin
                        state_q <= XB_IDLE;
                    end
                end
                default: state_q <= XB_IDLE;
            endcase
        end
    end

    // ----------------------------------------
    // Channel routing
    // ----------------------------------------
    always_comb begin
        o_mgr = '0;
        o_sub = '0;
        case (state_q)
            XB_ROUTE: begin
                if (!miss_q && rd_q) begin
                    o_sub[tgt_q].araddr  = w_req.araddr;
                    o_sub[tgt_q].arvalid = w_req.arvalid;
                    o_sub[tgt_q].rready  = w_req.rready;
                    o_mgr[sel_q].arready = w_rsp.arready;
                    o_mgr[sel_q].rdata   = w_rsp.rdata;
                    o_mgr[sel_q].rresp   = w_rsp.rresp;
                    o_mgr[sel_q].rvalid  = w_rsp.rvalid;
                end else if (!miss_q) begin
                    o_sub[tgt_q].awaddr  = w_req.awaddr;
                    o_sub[tgt_q].awvalid = w_req.awvalid;
                    o_sub[tgt_q].wdata   = w_req.wdata;
                    o_sub[tgt_q].wstrb   = w_req.wstrb;
                    o_sub[tgt_q].wvalid  = w_req.wvalid;
                    o_sub[tgt_q].bready  = w_req.bready;
                    o_mgr[sel_q].awready = w_rsp.awready;
                    o_mgr[sel_q].wready  = w_rsp.wready;
                    o_mgr[sel_q].bresp   = w_rsp.bresp;
                    o_mgr[sel_q].bvalid  = w_rsp.bvalid;
                end else if (rd_q) begin
                    // Unmapped read, swallow the address here
                    o_mgr[sel_q].arready = 1'b1;
                end else begin
                    o_mgr[sel_q].awready = w_req.awvalid && w_req.wvalid;
                    o_mgr[sel_q].wready  = w_req.awvalid && w_req.wvalid;
                end
            end
            XB_DONE: begin
                // Decode error response, held until the master takes it
                if (rd_q) begin
                    o_mgr[sel_q].rvalid = 1'b1;
                    o_mgr[sel_q].rresp  = DECERR;
                end else begin
                    o_mgr[sel_q].bvalid = 1'b1;
                    o_mgr[sel_q].bresp  = DECERR;
                end
            end
            default: begin
            end
        endcase
    end

endmodule : axil_xbar

`default_nettype wire

/* design/bus_to_axil.sv */
`timescale 1ns/1ps
`default_nettype none

module bus_to_axil
    import soc_bus_pkg::*;
#(
    parameter bit READ_ONLY = 1'b0
) (
    input  logic      i_clk,
    input  logic      i_rst_n,
    input  bus_req_t  i_bus,
    output bus_rsp_t  o_bus,
    output axil_req_t o_axil,
    input  axil_rsp_t i_axil
);

    adapter_state_t state_q;
    logic           awvalid_q;
    logic           wvalid_q;
    logic           arvalid_q;
    addr_t          addr_q;
    data_t          wdata_q;
    strb_t          wstrb_q;
    data_t          rdata_q;
    logic           err_q;

    logic w_accept;
    logic w_is_write;
    logic w_b_fire;
    logic w_r_fire;

    // Grant only while idle, so one request is in flight at a time
    assign w_accept   = i_bus.req && (state_q == ADP_IDLE);
    // Instruction side turns every request into a read
    assign w_is_write = i_bus.we && !READ_ONLY;
    assign w_b_fire   = i_axil.bvalid && (state_q == ADP_WRITE);
    assign w_r_fire   = i_axil.rvalid && (state_q == ADP_READ);

    // ----------------------------------------
    // Control FSM
    // ----------------------------------------
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q   <= ADP_IDLE;
            awvalid_q <= 1'b0;
            wvalid_q  <= 1'b0;
            arvalid_q <= 1'b0;
        end else begin
            case (state_q)
                ADP_IDLE: begin
                    if (w_accept && w_is_write) begin
                        state_q   <= ADP_WRITE;
                        awvalid_q <= 1'b1;
                        wvalid_q  <= 1'b1;
                    end else if (w_accept) begin
                        state_q   <= ADP_READ;
                        arvalid_q <= 1'b1;
                    end
                end
                ADP_WRITE: begin
                    // AW and W may be taken in different cycles
                    if (i_axil.awready) begin
                        awvalid_q <= 1'b0;
                    end
                    if (i_axil.wready) begin
                        wvalid_q <= 1'b0;
                    end
                    if (w_b_fire) begin
                        state_q <= ADP_RESP;
                    end
                end
                ADP_READ: begin
                    if (i_axil.arready) begin
                        arvalid_q <= 1'b0;
                    end
                    if (w_r_fire) begin
                        state_q <= ADP_RESP;
                    end
                end
                default: state_q <= ADP_IDLE;
            endcase
        end
    end

    // Request and response payload
    always_ff @(posedge i_clk) begin
        if (w_accept) begin
            addr_q  <= i_bus.addr;
            wdata_q <= i_bus.wdata;
            wstrb_q <= i_bus.wstrb;
        end
        if (w_b_fire) begin
            rdata_q <= '0;
            err_q   <= (i_axil.bresp != OKAY);
        end else if (w_r_fire) begin
            rdata_q <= i_axil.rdata;
            err_q   <= (i_axil.rresp != OKAY);
        end
    end

    always_comb begin
        o_bus.gnt      = w_accept;
        o_bus.rvalid   = (state_q == ADP_RESP);
        o_bus.rdata    = rdata_q;
        o_bus.err      = err_q;

        o_axil.awaddr  = addr_q;
        o_axil.awvalid = awvalid_q;
        o_axil.wdata   = wdata_q;
        o_axil.wstrb   = wstrb_q;
        o_axil.wvalid  = wvalid_q;
        o_axil.bready  = (state_q == ADP_WRITE);
        o_axil.araddr  = addr_q;
        o_axil.arvalid = arvalid_q;
        o_axil.rready  = (state_q == ADP_READ);
    end

endmodule : bus_to_axil

`default_nettype wire

/* design/soc_bus_pkg.sv */
`default_nettype none

`include "soc_defines.svh"

package soc_bus_pkg;

    typedef logic [`SOC_ADDR_W-1:0] addr_t;
    typedef logic [`SOC_DATA_W-1:0] data_t;
    typedef logic [`SOC_STRB_W-1:0] strb_t;

    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        EXOKAY = 2'b01,
        SLVERR = 2'b10,
        DECERR = 2'b11
    } axil_resp_t;

    // ----------------------------------------
    // Core-side request bus
    // ----------------------------------------
    typedef struct packed {
        logic  req;
        logic  we;
        addr_t addr;
        data_t wdata;
        strb_t wstrb;
    } bus_req_t;

    typedef struct packed {
        logic  gnt;
        logic  rvalid;
        data_t rdata;
        logic  err;
    } bus_rsp_t;

    // ----------------------------------------
    // AXI4-Lite, split by driving side
    // ----------------------------------------
    typedef struct packed {
        addr_t awaddr;
        logic  awvalid;
        data_t wdata;
        strb_t wstrb;
        logic  wvalid;
        logic  bready;
        addr_t araddr;
        logic  arvalid;
        logic  rready;
    } axil_req_t;

    typedef struct packed {
        logic       awready;
        logic       wready;
        axil_resp_t bresp;
        logic       bvalid;
        logic       arready;
        data_t      rdata;
        axil_resp_t rresp;
        logic       rvalid;
    } axil_rsp_t;

    typedef enum logic [1:0] {
        ADP_IDLE,
        ADP_WRITE,
        ADP_READ,
        ADP_RESP
    } adapter_state_t;

    typedef enum logic [1:0] {
        XB_IDLE,
        XB_ROUTE,
        XB_DONE
    } xbar_state_t;

endpackage : soc_bus_pkg

`default_nettype wire

/* design/soc_fabric_top.sv */
`timescale 1ns/1ps
`default_nettype none

module soc_fabric_top
    import soc_bus_pkg::*;
(
    input  logic      i_clk,
    input  logic      i_rst_n,
    input  bus_req_t  i_ibus,
    output bus_rsp_t  o_ibus,
    input  bus_req_t  i_dbus,
    output bus_rsp_t  o_dbus,
    output axil_req_t o_peri,
    input  axil_rsp_t i_peri
);

    // Index 0 is ibus / RAM, index 1 is dbus / peripheral
    axil_req_t [1:0] w_mgr_req;
    axil_rsp_t [1:0] w_mgr_rsp;
    axil_req_t [1:0] w_sub_req;
    axil_rsp_t [1:0] w_sub_rsp;

    // ----------------------------------------
    // Core bus adapters
    // ----------------------------------------
    bus_to_axil #(
        .READ_ONLY (1'b1)
    ) u_ibus_adapter (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_bus   (i_ibus),
        .o_bus   (o_ibus),
        .o_axil  (w_mgr_req[0]),
        .i_axil  (w_mgr_rsp[0])
    );

    bus_to_axil #(
        .READ_ONLY (1'b0)
    ) u_dbus_adapter (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_bus   (i_dbus),
        .o_bus   (o_dbus),
        .o_axil  (w_mgr_req[1]),
        .i_axil  (w_mgr_rsp[1])
    );

    axil_xbar u_xbar (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_mgr   (w_mgr_req),
        .o_mgr   (w_mgr_rsp),
        .o_sub   (w_sub_req),
        .i_sub   (w_sub_rsp)
    );

    axil_bram u_bram (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_axil  (w_sub_req[0]),
        .o_axil  (w_sub_rsp[0])
    );

    // Slave 1 leaves the fabric
    assign o_peri       = w_sub_req[1];
    assign w_sub_rsp[1] = i_peri;

endmodule : soc_fabric_top

`default_nettype wire

/* include/soc_defines.svh */
`ifndef SOC_DEFINES_SVH
`define SOC_DEFINES_SVH

// Bus widths
`define SOC_ADDR_W 32
`define SOC_DATA_W 32
`define SOC_STRB_W 4

// ----------------------------------------
// Address map
// ----------------------------------------

// On-chip RAM, one 4 KiB window
`define SOC_MEM_BASE  32'h0000_0000
`define SOC_MEM_MASK  32'hFFFF_F000
`define SOC_MEM_WORDS 1024

// Peripheral port, 256 MiB window
`define SOC_PERI_BASE 32'h4000_0000
`define SOC_PERI_MASK 32'hF000_0000

// Anything outside both windows gets DECERR

`endif

/* project.f */
+incdir+include
design/soc_bus_pkg.sv
design/bus_to_axil.sv
design/axil_xbar.sv
design/axil_bram.sv
design/soc_fabric_top.sv
verification/tb_clock_gen.sv
verification/tb_soc_fabric.sv

/* run_sim.sh */
#!/bin/sh
# Build the fabric testbench with Verilator, run it, and check the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f project.f --top-module tb_soc_fabric \
    -Mdir obj_dir \
    && ./obj_dir/Vtb_soc_fabric > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or simulation run failed"; exit 1; }
cat sim.log
grep -q "^TEST PASSED$" sim.log && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

/* verification/tb_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS    = 10,
    parameter int RESET_CYCLES = 10
) (
    output logic o_clk,
    output logic o_rst_n
);

    initial begin
        o_clk = 1'b0;
        forever #(PERIOD_NS / 2) o_clk = ~o_clk;
    end

    // Release just after a rising edge
    initial begin
        o_rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge o_clk);
        #1;
        o_rst_n = 1'b1;
    end

endmodule : tb_clock_gen

`default_nettype wire

/* verification/tb_soc_fabric.sv */
`timescale 1ns/1ps
`default_nettype none

`include "soc_defines.svh"

module tb_soc_fabric
    import soc_bus_pkg::*;
;

    localparam int RAM_WORDS_USED  = 64;
    localparam int PERI_REGS       = 16;
    localparam int N_RAM_PAIRS     = 24;
    localparam int N_IBUS          = 16;
    localparam int N_PERI_PAIRS    = 16;
    localparam int N_DECERR        = 12;
    localparam int N_DUAL          = 16;
    localparam int NUM_TXN         = 2 * RAM_WORDS_USED + 2 * N_RAM_PAIRS + N_IBUS
                                   + 2 * N_PERI_PAIRS + N_DECERR + 2 * N_DUAL;
    localparam int WATCHDOG_CYCLES = 200 * NUM_TXN + 20;

    logic      i_clk;
    logic      i_rst_n;
    bus_req_t  i_ibus;
    bus_req_t  i_dbus;
    bus_rsp_t  o_ibus;
    bus_rsp_t  o_dbus;
    axil_req_t o_peri;
    axil_rsp_t i_peri;

    logic [31:0] rng_state = 32'd9;
    data_t       ram_model [RAM_WORDS_USED];
    data_t       peri_regs [PERI_REGS];
    int          error_count = 0;
    int          check_count = 0;
    int          issued_ibus = 0;
    int          issued_dbus = 0;
    int          gnt_count_ibus = 0;
    int          gnt_count_dbus = 0;
    int          rvalid_count_ibus = 0;
    int          rvalid_count_dbus = 0;
    logic        peri_quiet = 1'b0;
    addr_t       exp_peri_addr;
    data_t       exp_peri_wdata;
    strb_t       exp_peri_wstrb;

    tb_clock_gen #(
        .PERIOD_NS    (10),
        .RESET_CYCLES (10)
    ) u_clock_gen (
        .o_clk   (i_clk),
        .o_rst_n (i_rst_n)
    );

    soc_fabric_top dut (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_ibus  (i_ibus),
        .o_ibus  (o_ibus),
        .i_dbus  (i_dbus),
        .o_dbus  (o_dbus),
        .o_peri  (o_peri),
        .i_peri  (i_peri)
    );

    // ----------------------------------------
    // Helpers
    // ----------------------------------------
    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] rand32();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    function automatic data_t byte_merge(input data_t old_word, input data_t new_word,
                                         input strb_t strb);
        data_t result;
        result = old_word;
        for (int b = 0; b < `SOC_STRB_W; b++) begin
            if (strb[b]) begin
                result[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return result;
    endfunction

    function automatic addr_t ram_addr(input int idx);
        return `SOC_MEM_BASE + (32'(idx) << 2);
    endfunction

    // Random upper bits inside the window with the register index in bits 5:2
    function automatic addr_t peri_addr(input int idx);
        return `SOC_PERI_BASE | (rand32() & 32'h0FFF_FFC0) | (32'(idx) << 2);
    endfunction

    function automatic addr_t unmapped_addr();
        logic [31:0] r;
        r = rand32();
        // Top nibble 1 or 8 is outside both windows
        return (r & 32'h0FFF_FFFC) | (r[31] ? 32'h8000_0000 : 32'h1000_0000);
    endfunction

    function automatic bus_req_t make_req(input logic we, input addr_t addr,
                                          input data_t wdata, input strb_t wstrb);
        bus_req_t req;
        req.req   = 1'b1;
        req.we    = we;
        req.addr  = addr;
        req.wdata = wdata;
        req.wstrb = wstrb;
        return req;
    endfunction

    function automatic bus_rsp_t bus_response(input bit is_ibus);
        return is_ibus ? o_ibus : o_dbus;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        check_count++;
        assert (got === exp) else begin
            error_count++;
            $display("CHECK FAILED %s got 0x%08h expected 0x%08h at time %0t",
                     name, got, exp, $time);
        end
    endtask

    task automatic drive_bus(input bit is_ibus, input bus_req_t req);
        if (is_ibus) begin
            i_ibus = req;
        end else begin
            i_dbus = req;
        end
    endtask

    // Moves to 1 ns after the (n+1)th rising edge
    task automatic advance(input int n);
        repeat (n + 1) @(posedge i_clk);
        #1;
    endtask

    task automatic check_reset_state();
        check_value("o_ibus.gnt", 32'(o_ibus.gnt), 32'd0);
        check_value("o_ibus.rvalid", 32'(o_ibus.rvalid), 32'd0);
        check_value("o_dbus.gnt", 32'(o_dbus.gnt), 32'd0);
        check_value("o_dbus.rvalid", 32'(o_dbus.rvalid), 32'd0);
        check_value("o_peri.awvalid", 32'(o_peri.awvalid), 32'd0);
        check_value("o_peri.wvalid", 32'(o_peri.wvalid), 32'd0);
        check_value("o_peri.arvalid", 32'(o_peri.arvalid), 32'd0);
    endtask

    // One core-side transfer with request, gnt and a single rvalid pulse
    task automatic run_access(input bit is_ibus, input bus_req_t req, input bit check_data,
                              input data_t exp_rdata, input bit exp_err);
        bus_rsp_t rsp;
        string    name;
        name = is_ibus ? "o_ibus" : "o_dbus";
        @(posedge i_clk);
        #1;
        drive_bus(is_ibus, req);
        if (is_ibus) begin
            issued_ibus++;
        end else begin
            issued_dbus++;
        end
        @(negedge i_clk);
        rsp = bus_response(is_ibus);
        while (!rsp.gnt) begin
            @(negedge i_clk);
            rsp = bus_response(is_ibus);
        end
        @(posedge i_clk);
        #1;
        drive_bus(is_ibus, '0);
        do begin
            @(negedge i_clk);
            rsp = bus_response(is_ibus);
        end while (!rsp.rvalid);
        if (check_data) begin
            check_value({name, ".rdata"}, rsp.rdata, exp_rdata);
        end
        check_value({name, ".err"}, 32'(rsp.err), 32'(exp_err));
        @(negedge i_clk);
        rsp = bus_response(is_ibus);
        check_value({name, ".rvalid"}, 32'(rsp.rvalid), 32'd0);
    endtask

    // ----------------------------------------
    // Peripheral responder
    // ----------------------------------------
    initial begin
        logic [3:0] idx;
        data_t      wdata;
        strb_t      wstrb;
        i_peri = '0;
        forever begin
            @(negedge i_clk);
            if (o_peri.arvalid) begin
                check_value("o_peri.araddr", o_peri.araddr, exp_peri_addr);
                idx = o_peri.araddr[5:2];
                advance(int'(rand32() & 32'd3));
                i_peri.arready = 1'b1;
                advance(0);
                i_peri.arready = 1'b0;
                advance(int'(rand32() & 32'd3));
                i_peri.rvalid = 1'b1;
                i_peri.rdata  = peri_regs[idx];
                i_peri.rresp  = OKAY;
                @(negedge i_clk);
                while (!o_peri.rready) @(negedge i_clk);
                advance(0);
                i_peri.rvalid = 1'b0;
            end else if (o_peri.awvalid && o_peri.wvalid) begin
                check_value("o_peri.awaddr", o_peri.awaddr, exp_peri_addr);
                check_value("o_peri.wdata", o_peri.wdata, exp_peri_wdata);
                check_value("o_peri.wstrb", 32'(o_peri.wstrb), 32'(exp_peri_wstrb));
                idx   = o_peri.awaddr[5:2];
                wdata = o_peri.wdata;
                wstrb = o_peri.wstrb;
                advance(int'(rand32() & 32'd3));
                i_peri.awready = 1'b1;
                i_peri.wready  = 1'b1;
                advance(0);
                i_peri.awready = 1'b0;
                i_peri.wready  = 1'b0;
                peri_regs[idx] = byte_merge(peri_regs[idx], wdata, wstrb);
                advance(int'(rand32() & 32'd3));
                i_peri.bvalid = 1'b1;
                i_peri.bresp  = OKAY;
                @(negedge i_clk);
                while (!o_peri.bready) @(negedge i_clk);
                advance(0);
                i_peri.bvalid = 1'b0;
            end
        end
    end

    // ----------------------------------------
    // Monitors
    // ----------------------------------------
    initial begin
        @(negedge i_clk);
        while (!i_rst_n) begin
            check_reset_state();
            @(negedge i_clk);
        end
        // First cycle out of reset
        check_reset_state();
    end

    always @(negedge i_clk) begin
        if (peri_quiet) begin
            check_value("o_peri.awvalid", 32'(o_peri.awvalid), 32'd0);
            check_value("o_peri.wvalid", 32'(o_peri.wvalid), 32'd0);
            check_value("o_peri.arvalid", 32'(o_peri.arvalid), 32'd0);
        end
        if (o_ibus.gnt) gnt_count_ibus++;
        if (o_dbus.gnt) gnt_count_dbus++;
        if (o_ibus.rvalid) rvalid_count_ibus++;
        if (o_dbus.rvalid) rvalid_count_dbus++;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge i_clk);
        $display("Watchdog expired after %0d cycles with transactions still open",
                 WATCHDOG_CYCLES);
        $display("Summary: %0d checks, %0d errors", check_count, error_count);
        $display("TEST FAILED");
        $finish;
    end

    // ----------------------------------------
    // Test sequence
    // ----------------------------------------
    initial begin
        int          idx;
        int          a;
        int          b;
        logic [31:0] r;
        data_t       wdata;
        data_t       expected;
        strb_t       strb;
        addr_t       addr;

        i_ibus = '0;
        i_dbus = '0;
        for (int i = 0; i < PERI_REGS; i++) begin
            peri_regs[i] = rand32();
        end
        wait (i_rst_n === 1'b1);
        repeat (2) @(posedge i_clk);

        // Full-word fill of the RAM window under test
        for (int i = 0; i < RAM_WORDS_USED; i++) begin
            wdata = rand32();
            run_access(1'b0, make_req(1'b1, ram_addr(i), wdata, 4'hF), 1'b0, '0, 1'b0);
            ram_model[i] = wdata;
        end

        // Partial writes then read back on dbus
        for (int n = 0; n < N_RAM_PAIRS; n++) begin
            idx   = int'(rand32() % RAM_WORDS_USED);
            wdata = rand32();
            r     = rand32();
            strb  = r[3:0];
            run_access(1'b0, make_req(1'b1, ram_addr(idx), wdata, strb), 1'b0, '0, 1'b0);
            ram_model[idx] = byte_merge(ram_model[idx], wdata, strb);
            run_access(1'b0, make_req(1'b0, ram_addr(idx), '0, '0), 1'b1, ram_model[idx],
                       1'b0);
        end

        // ibus reads that sometimes set we
        for (int n = 0; n < N_IBUS; n++) begin
            idx = int'(rand32() % RAM_WORDS_USED);
            r   = rand32();
            run_access(1'b1, make_req(r[0], ram_addr(idx), rand32(), r[7:4]), 1'b1,
                       ram_model[idx], 1'b0);
        end

        // Peripheral write then read back
        for (int n = 0; n < N_PERI_PAIRS; n++) begin
            idx            = int'(rand32() % PERI_REGS);
            addr           = peri_addr(idx);
            wdata          = rand32();
            r              = rand32();
            strb           = r[3:0];
            exp_peri_addr  = addr;
            exp_peri_wdata = wdata;
            exp_peri_wstrb = strb;
            expected       = byte_merge(peri_regs[idx], wdata, strb);
            run_access(1'b0, make_req(1'b1, addr, wdata, strb), 1'b0, '0, 1'b0);
            addr          = peri_addr(idx);
            exp_peri_addr = addr;
            run_access(1'b0, make_req(1'b0, addr, '0, '0), 1'b1, expected, 1'b0);
        end

        // Unmapped addresses
        peri_quiet = 1'b1;
        for (int n = 0; n < N_DECERR; n++) begin
            r = rand32();
            run_access(r[1], make_req(r[2], unmapped_addr(), rand32(), 4'hF), 1'b0, '0,
                       1'b1);
        end
        peri_quiet = 1'b0;

        // Both buses in the same cycle, dbus either reads or writes
        for (int n = 0; n < N_DUAL; n++) begin
            a        = int'(rand32() % RAM_WORDS_USED);
            b        = (a + 1 + int'(rand32() % (RAM_WORDS_USED - 1))) % RAM_WORDS_USED;
            wdata    = rand32();
            r        = rand32();
            strb     = r[3:0];
            expected = ram_model[a];
            fork
                run_access(1'b1, make_req(1'b0, ram_addr(a), '0, '0), 1'b1, expected, 1'b0);
                run_access(1'b0, make_req(r[4], ram_addr(b), wdata, strb), !r[4],
                           ram_model[b], 1'b0);
            join
            if (r[4]) begin
                ram_model[b] = byte_merge(ram_model[b], wdata, strb);
            end
        end

        // Final sweep of the RAM window
        for (int i = 0; i < RAM_WORDS_USED; i++) begin
            run_access(1'b0, make_req(1'b0, ram_addr(i), '0, '0), 1'b1, ram_model[i], 1'b0);
        end

        repeat (4) @(posedge i_clk);
        check_value("o_ibus.gnt count", gnt_count_ibus, issued_ibus);
        check_value("o_ibus.rvalid count", rvalid_count_ibus, issued_ibus);
        check_value("o_dbus.gnt count", gnt_count_dbus, issued_dbus);
        check_value("o_dbus.rvalid count", rvalid_count_dbus, issued_dbus);
        $display("Summary: %0d checks, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule : tb_soc_fabric

`default_nettype wire
